// File: include/htif_config.svh
`ifndef HTIF_CONFIG_SVH
`define HTIF_CONFIG_SVH

// Bus and host channel widths
`define HTIF_WORD_W      32
`define HTIF_HALF_W      16
`define HTIF_ID_W        12
`define HTIF_ADDR_W      32

// Register index field inside the AXI address
`define HTIF_REG_LSB     2
`define HTIF_REG_MSB     6

`define HTIF_FIFO_DEPTH  32  // Words, power of two

// Register map
`define HTIF_REG_COUNT   0   // Read
`define HTIF_REG_DATA_RD 1   // Read
`define HTIF_REG_DATA_WR 0   // Write
`define HTIF_REG_RESET   31  // Write

`endif

// File: rtl/htif_pkg.sv
`include "htif_config.svh"

package htif_pkg;

  // ----------------------------------------
  // Data and bus types
  // ----------------------------------------
  typedef logic [`HTIF_WORD_W-1:0] word_t;
  typedef logic [`HTIF_HALF_W-1:0] half_t;
  typedef logic [`HTIF_ID_W-1:0]   axi_id_t;
  typedef logic [`HTIF_ADDR_W-1:0] axi_addr_t;

  typedef logic [`HTIF_REG_MSB-`HTIF_REG_LSB:0] reg_idx_t;

  // Holds 0 up to a full FIFO
  typedef logic [$clog2(`HTIF_FIFO_DEPTH+1)-1:0] fifo_count_t;

  // ----------------------------------------
  // Register indexes and FSM states
  // ----------------------------------------
  typedef enum reg_idx_t {
    RD_COUNT = `HTIF_REG_COUNT,
    RD_DATA  = `HTIF_REG_DATA_RD
  } rd_reg_e;

  typedef enum reg_idx_t {
    WR_DATA  = `HTIF_REG_DATA_WR,
    WR_RESET = `HTIF_REG_RESET
  } wr_reg_e;

  typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;

  typedef enum logic [1:0] {WR_IDLE, WR_COMMIT, WR_RESP} wr_state_e;

endpackage

// File: rtl/htif_fifo_if.sv
`timescale 1ns/100ps

// Links the register slave with the inbound and outbound queues
interface htif_fifo_if;
  import htif_pkg::*;

  // Toward the chip
  logic        in_wren;
  word_t       in_data;
  logic        in_full;

  // From the chip
  logic        out_rden;
  word_t       out_data;
  fifo_count_t out_count;

  modport axi_side (
    output in_wren, in_data, out_rden,
    input  in_full, out_data, out_count
  );

  modport in_side (
    input  in_wren, in_data,
    output in_full
  );

  modport out_side (
    input  out_rden,
    output out_data, out_count
  );

endinterface

// File: rtl/htif_fifo.sv
`timescale 1ns/100ps
`include "htif_config.svh"

module htif_fifo #(
  parameter int DEPTH = `HTIF_FIFO_DEPTH
) (
  input  logic                  userclk2,
  input  logic                  reset,
  input  logic                  wren,
  input  logic                  rden,
  input  htif_pkg::word_t       din,
  output htif_pkg::word_t       dout,
  output logic                  empty,
  output logic                  full,
  output htif_pkg::fifo_count_t count
);
  import htif_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  fifo_count_t      count_next;
  logic             write;
  logic             read;

  assign write = wren && !full;   // Dropped when full
  assign read  = rden && !empty;  // Dropped when empty

  assign dout = mem[rd_ptr];      // Head word, no read latency

  always_comb
  begin
    count_next = count;
    if (write && !read)
      count_next = count + 1'b1;
    else if (read && !write)
      count_next = count - 1'b1;
  end

  // Pointers, count and flags
  always_ff @(posedge userclk2)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
    end
    else
    begin
      if (write)
        wr_ptr <= wr_ptr + 1'b1;
      if (read)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count_next;
      empty <= (count_next == '0);
      full  <= (count_next == fifo_count_t'(DEPTH));
    end
  end

  // Storage
  always_ff @(posedge userclk2)
  begin
    if (write)
      mem[wr_ptr] <= din;
  end

  a_count_bound: assert property (
    @(posedge userclk2) disable iff (reset)
    count <= fifo_count_t'(DEPTH)
  ) else $error("FIFO count above depth");

endmodule

// File: rtl/host_in_path.sv
`timescale 1ns/100ps
`include "htif_config.svh"

module host_in_path (
  input  logic            userclk2,
  input  logic            reset,
  htif_fifo_if.in_side    fifo,
  output logic            host_in_valid,
  input  logic            host_in_ready,
  output htif_pkg::half_t host_in_bits
);
  import htif_pkg::*;

  word_t head;
  logic  empty;
  logic  half_sel;   // 0 while the low half is offered
  logic  handshake;

  htif_fifo u_fifo (
    .userclk2 (userclk2),
    .reset    (reset),
    .wren     (fifo.in_wren),
    .rden     (handshake && half_sel),  // Pop after the high half
    .din      (fifo.in_data),
    .dout     (head),
    .empty    (empty),
    .full     (fifo.in_full),
    .count    ()
  );

  assign host_in_valid = !empty;
  assign handshake     = host_in_valid && host_in_ready;

  // Low half goes first
  assign host_in_bits = half_sel ? head[`HTIF_WORD_W-1:`HTIF_HALF_W]
                                 : head[`HTIF_HALF_W-1:0];

  always_ff @(posedge userclk2)
  begin
    if (reset)
      half_sel <= 1'b0;
    else if (handshake)
      half_sel <= !half_sel;
  end

  // Offered half must not move while the chip stalls
  a_bits_hold: assert property (
    @(posedge userclk2) disable iff (reset)
    host_in_valid && !host_in_ready |=> $stable(host_in_bits)
  ) else $error("host_in_bits changed under back-pressure");

endmodule

// File: rtl/host_out_path.sv
`timescale 1ns/100ps

module host_out_path (
  input  logic            userclk2,
  input  logic            reset,
  htif_fifo_if.out_side   fifo,
  input  logic            host_out_valid,
  output logic            host_out_ready,
  input  htif_pkg::half_t host_out_bits
);
  import htif_pkg::*;

  half_t low_r;      // First half of the pending word
  logic  half_sel;   // Set once the low half is held
  logic  full;
  logic  handshake;

  // ----------------------------------------
  // Half-word packer
  // ----------------------------------------
  assign host_out_ready = !full;   // Even a low half waits on a full FIFO
  assign handshake      = host_out_valid && host_out_ready;

  always_ff @(posedge userclk2)
  begin
    if (reset)
      half_sel <= 1'b0;
    else if (handshake)
      half_sel <= !half_sel;
  end

  always_ff @(posedge userclk2)
  begin
    if (handshake && !half_sel)
      low_r <= host_out_bits;
  end

  // ----------------------------------------
  // Word queue toward the processor
  // ----------------------------------------
  htif_fifo u_fifo (
    .userclk2 (userclk2),
    .reset    (reset),
    .wren     (handshake && half_sel),    // Written with the high half
    .rden     (fifo.out_rden),
    .din      ({host_out_bits, low_r}),
    .dout     (fifo.out_data),
    .empty    (),
    .full     (full),
    .count    (fifo.out_count)
  );

endmodule

// File: rtl/htif_axi_slave.sv
`timescale 1ns/100ps
`include "htif_config.svh"

module htif_axi_slave (
  input  logic                userclk2,
  input  logic                reset,
  // Write address and data
  input  htif_pkg::axi_addr_t awaddr,
  input  htif_pkg::axi_id_t   awid,
  input  logic                awvalid,
  output logic                awready,
  input  htif_pkg::word_t     wdata,
  input  logic                wvalid,
  output logic                wready,
  // Write response
  output htif_pkg::axi_id_t   bid,
  output logic                bvalid,
  input  logic                bready,
  // Read address and data
  input  htif_pkg::axi_addr_t araddr,
  input  htif_pkg::axi_id_t   arid,
  input  logic                arvalid,
  output logic                arready,
  output htif_pkg::word_t     rdata,
  output htif_pkg::axi_id_t   rid,
  output logic                rvalid,
  output logic                rlast,
  input  logic                rready,
  output logic                cpu_reset,
  htif_fifo_if.axi_side       fifo
);
  import htif_pkg::*;

  wr_state_e wr_state;
  rd_state_e rd_state;
  reg_idx_t  wr_idx;
  reg_idx_t  rd_idx;
  axi_id_t   awid_r;
  axi_id_t   arid_r;
  logic      wr_commit;

  // ----------------------------------------
  // Write channel
  // ----------------------------------------

  // Data writes wait for room, anything else goes straight through
  assign wr_commit = (wr_state == WR_COMMIT) && !((wr_idx == WR_DATA) && fifo.in_full);

  always_ff @(posedge userclk2)
  begin
    if (reset)
      wr_state <= WR_IDLE;
    else
    begin
      case (wr_state)
        WR_IDLE:
        begin
          if (awvalid && wvalid)
            wr_state <= WR_COMMIT;
        end
        WR_COMMIT:
        begin
          if (wr_commit)
            wr_state <= WR_RESP;
        end
        WR_RESP:
        begin
          if (bready)
            wr_state <= WR_IDLE;
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge userclk2)
  begin
    if ((wr_state == WR_IDLE) && awvalid && wvalid)
    begin
      wr_idx <= awaddr[`HTIF_REG_MSB:`HTIF_REG_LSB];
      awid_r <= awid;
    end
  end

  assign awready      = wr_commit;   // Both accepted in the commit cycle
  assign wready       = wr_commit;
  assign fifo.in_wren = wr_commit && (wr_idx == WR_DATA);
  assign fifo.in_data = wdata;       // Still held by the master here
  assign cpu_reset    = wr_commit && (wr_idx == WR_RESET);

  assign bvalid = (wr_state == WR_RESP);
  assign bid    = awid_r;

  // ----------------------------------------
  // Read channel
  // ----------------------------------------
  always_ff @(posedge userclk2)
  begin
    if (reset)
      rd_state <= RD_IDLE;
    else
    begin
      case (rd_state)
        RD_IDLE:
        begin
          if (arvalid)
            rd_state <= RD_RESP;
        end
        RD_RESP:
        begin
          if (rready)
            rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge userclk2)
  begin
    if ((rd_state == RD_IDLE) && arvalid)
    begin
      rd_idx <= araddr[`HTIF_REG_MSB:`HTIF_REG_LSB];
      arid_r <= arid;
    end
  end

  assign arready = (rd_state == RD_IDLE);
  assign rvalid  = (rd_state == RD_RESP);
  assign rlast   = (rd_state == RD_RESP);   // Single beat only
  assign rid     = arid_r;

  // Count in the low bits, every other index reads the head word
  assign rdata = (rd_idx == RD_COUNT) ? word_t'(fifo.out_count) : fifo.out_data;

  assign fifo.out_rden = rvalid && rready && (rd_idx == RD_DATA);

  a_bvalid_hold: assert property (
    @(posedge userclk2) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bid)
  ) else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (
    @(posedge userclk2) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rid)
  ) else $error("rvalid dropped before rready");

endmodule

// File: rtl/htif_bridge.sv
`timescale 1ns/100ps

module htif_bridge (
  input  logic                userclk2,
  input  logic                reset,
  // AXI slave port
  input  htif_pkg::axi_addr_t awaddr,
  input  htif_pkg::axi_id_t   awid,
  input  logic                awvalid,
  output logic                awready,
  input  htif_pkg::word_t     wdata,
  input  logic                wvalid,
  output logic                wready,
  output htif_pkg::axi_id_t   bid,
  output logic                bvalid,
  input  logic                bready,
  input  htif_pkg::axi_addr_t araddr,
  input  htif_pkg::axi_id_t   arid,
  input  logic                arvalid,
  output logic                arready,
  output htif_pkg::word_t     rdata,
  output htif_pkg::axi_id_t   rid,
  output logic                rvalid,
  output logic                rlast,
  input  logic                rready,
  // Test chip side
  output logic                cpu_reset,
  output logic                host_in_valid,
  input  logic                host_in_ready,
  output htif_pkg::half_t     host_in_bits,
  input  logic                host_out_valid,
  output logic                host_out_ready,
  input  htif_pkg::half_t     host_out_bits
);

  htif_fifo_if fifo_bus ();

  htif_axi_slave u_axi_slave (
    .userclk2  (userclk2),
    .reset     (reset),
    .awaddr    (awaddr),
    .awid      (awid),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bid       (bid),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arid      (arid),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rid       (rid),
    .rvalid    (rvalid),
    .rlast     (rlast),
    .rready    (rready),
    .cpu_reset (cpu_reset),
    .fifo      (fifo_bus.axi_side)
  );

  // Processor to chip
  host_in_path u_host_in (
    .userclk2      (userclk2),
    .reset         (reset),
    .fifo          (fifo_bus.in_side),
    .host_in_valid (host_in_valid),
    .host_in_ready (host_in_ready),
    .host_in_bits  (host_in_bits)
  );

  // Chip to processor
  host_out_path u_host_out (
    .userclk2       (userclk2),
    .reset          (reset),
    .fifo           (fifo_bus.out_side),
    .host_out_valid (host_out_valid),
    .host_out_ready (host_out_ready),
    .host_out_bits  (host_out_bits)
  );

endmodule

// File: test/htif_tb.sv
`timescale 1ns/100ps
`include "htif_config.svh"

module htif_tb;
  import htif_pkg::*;

  typedef half_t [1:0] half_pair_t;

  localparam int        TIMEOUT_CYCLES = 20000;  // Well above the length of the test
  localparam int        N_WORDS        = 12;
  localparam int        DEPTH          = `HTIF_FIFO_DEPTH;
  localparam axi_addr_t ADDR_WR_DATA   = axi_addr_t'(`HTIF_REG_DATA_WR) << `HTIF_REG_LSB;
  localparam axi_addr_t ADDR_WR_RESET  = axi_addr_t'(`HTIF_REG_RESET) << `HTIF_REG_LSB;
  localparam axi_addr_t ADDR_RD_COUNT  = axi_addr_t'(`HTIF_REG_COUNT) << `HTIF_REG_LSB;
  localparam axi_addr_t ADDR_RD_DATA   = axi_addr_t'(`HTIF_REG_DATA_RD) << `HTIF_REG_LSB;

  logic      userclk2;
  logic      reset;
  axi_addr_t awaddr;
  axi_id_t   awid;
  logic      awvalid;
  logic      awready;
  word_t     wdata;
  logic      wvalid;
  logic      wready;
  axi_id_t   bid;
  logic      bvalid;
  logic      bready;
  axi_addr_t araddr;
  axi_id_t   arid;
  logic      arvalid;
  logic      arready;
  word_t     rdata;
  axi_id_t   rid;
  logic      rvalid;
  logic      rlast;
  logic      rready;
  logic      cpu_reset;
  logic      host_in_valid;
  logic      host_in_ready;
  half_t     host_in_bits;
  logic      host_out_valid;
  logic      host_out_ready;
  half_t     host_out_bits;

  logic [15:0] lfsr = 16'd12915;
  half_t       exp_in_q[$];    // Half-words still owed on host_in
  word_t       exp_out_q[$];   // Words queued from host_out
  half_t       out_low;
  logic        out_has_low = 1'b0;
  logic        writes_done = 1'b0;
  int          reset_pulses = 0;
  int          cycle_count = 0;
  int          pulses_before;
  word_t       words [N_WORDS];
  axi_id_t     ids [N_WORDS];
  word_t       tmp;

  htif_bridge DUT (.*);

  initial
  begin
    userclk2 = 1'b0;
    forever #20 userclk2 = ~userclk2;
  end

  // ----------------------------------------
  // Helpers and reference model
  // ----------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[`HTIF_WORD_W-2:0], lfsr[0]};  // One step per bit
    end
  endtask

  // Low half travels first
  function automatic half_pair_t split_word(input word_t w);
    half_pair_t p;
    p[0] = w[`HTIF_HALF_W-1:0];
    p[1] = w[`HTIF_WORD_W-1:`HTIF_HALF_W];
    return p;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_half(input string name, input half_t got, input half_t exp);
    if (got !== exp)
      stop_run($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      stop_run($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp));
  endtask

  task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
    if (got !== exp)
      stop_run($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp));
  endtask

  task automatic check_count(input string name, input fifo_count_t got,
                             input fifo_count_t exp);
    if (got !== exp)
      stop_run($sformatf("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, exp));
  endtask

  // ----------------------------------------
  // Bus and host drivers
  // ----------------------------------------
  task automatic axi_write(input axi_addr_t addr, input axi_id_t id, input word_t data);
    half_pair_t halves;
    awaddr  <= addr;
    awid    <= id;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge userclk2); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    if (addr[`HTIF_REG_MSB:`HTIF_REG_LSB] == `HTIF_REG_DATA_WR)
    begin
      halves = split_word(data);
      exp_in_q.push_back(halves[0]);
      exp_in_q.push_back(halves[1]);
    end
    do @(posedge userclk2); while (!bvalid);
    check_id("bid", bid, id);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output word_t data);
    word_t   r;
    axi_id_t id;
    take_bits(`HTIF_ID_W, r);
    id = axi_id_t'(r);
    araddr  <= addr;
    arid    <= id;
    arvalid <= 1'b1;
    do @(posedge userclk2); while (!arready);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    do @(posedge userclk2); while (!rvalid);
    data = rdata;
    check_id("rid", rid, id);
    rready <= 1'b0;
  endtask

  task automatic read_count(input int exp);
    word_t rd;
    axi_read(ADDR_RD_COUNT, rd);
    check_count("rdata count", fifo_count_t'(rd), fifo_count_t'(exp));
    check_word("rdata", rd, word_t'(exp));   // Zeros above the count
  endtask

  task automatic read_word();
    word_t rd;
    axi_read(ADDR_RD_DATA, rd);
    check_word("rdata", rd, exp_out_q.pop_front());
  endtask

  // Leaves valid high for the caller to drop after the last half
  task automatic send_half(input half_t h);
    host_out_valid <= 1'b1;
    host_out_bits  <= h;
    do @(posedge userclk2); while (!host_out_ready);
    if (!out_has_low)
      out_low = h;
    else
      exp_out_q.push_back({h, out_low});
    out_has_low = !out_has_low;
  endtask

  // ----------------------------------------
  // Monitors
  // ----------------------------------------
  always @(posedge userclk2)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_run("Timeout: the test did not finish within the cycle limit");
  end

  always @(posedge userclk2)
  begin
    if (!reset)
    begin
      if (host_in_valid && host_in_ready)
      begin
        if (exp_in_q.size() == 0)
          stop_run("host_in delivered a half-word that was never written");
        else
          check_half("host_in_bits", host_in_bits, exp_in_q.pop_front());
      end
      if (rvalid && !rlast)
        stop_run("rlast was low while rvalid was high");
      if (cpu_reset && !awready)
        stop_run("cpu_reset was high outside a write commit cycle");
      if (cpu_reset)
        reset_pulses++;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    reset          = 1'b1;
    awaddr         = '0;
    awid           = '0;
    awvalid        = 1'b0;
    wdata          = '0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    araddr         = '0;
    arid           = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    host_in_ready  = 1'b0;
    host_out_valid = 1'b0;
    host_out_bits  = '0;
    repeat (4) @(posedge userclk2);
    reset <= 1'b0;
    @(posedge userclk2);
    if (!arready || !host_out_ready || rvalid || bvalid || awready || wready ||
        cpu_reset || host_in_valid)
      stop_run("Outputs were not at their reset values after reset");

    // Data words to the chip with a random host_in_ready
    for (int i = 0; i < N_WORDS; i++)
    begin
      take_bits(`HTIF_WORD_W, words[i]);
      take_bits(`HTIF_ID_W, tmp);
      ids[i] = axi_id_t'(tmp);
    end
    fork
      begin
        for (int i = 0; i < N_WORDS; i++)
          axi_write(ADDR_WR_DATA, ids[i], words[i]);
        writes_done = 1'b1;
      end
      while (!writes_done || exp_in_q.size() != 0)
      begin
        @(posedge userclk2);
        take_bits(1, tmp);
        host_in_ready <= tmp[0];
      end
    join
    host_in_ready <= 1'b0;

    // Half-words from the chip with an odd trailing half left pending
    for (int i = 0; i < 2 * N_WORDS + 1; i++)
    begin
      take_bits(`HTIF_HALF_W, tmp);
      send_half(half_t'(tmp));
    end
    host_out_valid <= 1'b0;
    read_count(N_WORDS);
    repeat (N_WORDS) read_word();
    take_bits(`HTIF_HALF_W, tmp);
    send_half(half_t'(tmp));
    host_out_valid <= 1'b0;
    read_count(1);
    read_word();

    // Reset register pulses cpu_reset and queues nothing
    host_in_ready <= 1'b1;
    pulses_before = reset_pulses;
    take_bits(`HTIF_WORD_W, tmp);
    axi_write(ADDR_WR_RESET, ids[0], tmp);
    repeat (4)
    begin
      @(posedge userclk2);
      if (host_in_valid)
        stop_run("host_in_valid rose after a reset register write");
    end
    if (reset_pulses != pulses_before + 1)
      stop_run("cpu_reset was not high for exactly one cycle");
    host_in_ready <= 1'b0;

    // Inbound back-pressure with the chip stalled and the FIFO filled
    for (int i = 0; i < DEPTH; i++)
    begin
      take_bits(`HTIF_WORD_W, tmp);
      axi_write(ADDR_WR_DATA, ids[i % N_WORDS], tmp);
    end
    take_bits(`HTIF_WORD_W, tmp);
    fork
      axi_write(ADDR_WR_DATA, ids[1], tmp);
      begin
        repeat (8)
        begin
          @(posedge userclk2);
          if (wready)
            stop_run("wready rose while the inbound FIFO was full");
        end
        host_in_ready <= 1'b1;
        repeat (2)
        begin
          do
          begin
            @(posedge userclk2);
            if (wready)
              stop_run("wready rose before a whole word was drained");
          end
          while (!(host_in_valid && host_in_ready));
        end
        host_in_ready <= 1'b0;   // Exactly one word drained
      end
    join
    host_in_ready <= 1'b1;
    while (exp_in_q.size() != 0)
      @(posedge userclk2);
    host_in_ready <= 1'b0;

    // Outbound back-pressure
    for (int i = 0; i < 2 * DEPTH; i++)
    begin
      take_bits(`HTIF_HALF_W, tmp);
      send_half(half_t'(tmp));
    end
    host_out_valid <= 1'b0;
    @(posedge userclk2);
    if (host_out_ready)
      stop_run("host_out_ready stayed high with the outbound FIFO full");
    read_count(DEPTH);
    repeat (DEPTH) read_word();

    @(posedge userclk2);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: files.f
+incdir+include
rtl/htif_pkg.sv
rtl/htif_fifo_if.sv
rtl/htif_fifo.sv
rtl/host_in_path.sv
rtl/host_out_path.sv
rtl/htif_axi_slave.sv
rtl/htif_bridge.sv
test/htif_tb.sv
